/* logic/ex_pkg.sv */
package ex_pkg;

    localparam int MULT_BITS_DEFAULT = 2; // multiplier bits per step

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regaddr_t;

    typedef enum logic [7:0] {
        EXE_NOP_OP   = 8'b0000_0000,
        EXE_SRL_OP   = 8'b0000_0010,
        EXE_SRA_OP   = 8'b0000_0011,
        EXE_MOVZ_OP  = 8'b0000_1010,
        EXE_MOVN_OP  = 8'b0000_1011,
        EXE_MFHI_OP  = 8'b0001_0000,
        EXE_MTHI_OP  = 8'b0001_0001,
        EXE_MFLO_OP  = 8'b0001_0010,
        EXE_MTLO_OP  = 8'b0001_0011,
        EXE_MULT_OP  = 8'b0001_1000,
        EXE_MULTU_OP = 8'b0001_1001,
        EXE_ADD_OP   = 8'b0010_0000, // also ADDI
        EXE_ADDU_OP  = 8'b0010_0001, // also ADDIU
        EXE_SUB_OP   = 8'b0010_0010,
        EXE_SUBU_OP  = 8'b0010_0011,
        EXE_AND_OP   = 8'b0010_0100,
        EXE_OR_OP    = 8'b0010_0101,
        EXE_XOR_OP   = 8'b0010_0110,
        EXE_NOR_OP   = 8'b0010_0111,
        EXE_SLL_OP   = 8'b0111_1100
    } aluop_t;

    typedef enum logic [2:0] {
        EXE_RES_NOP         = 3'b000,
        EXE_RES_LOGIC       = 3'b001,
        EXE_RES_SHIFT       = 3'b010,
        EXE_RES_MOVE        = 3'b011,
        EXE_RES_ARITHMETIC  = 3'b100,
        EXE_RES_MUL         = 3'b101,
        EXE_RES_JUMP_BRANCH = 3'b110
    } alusel_t;

    typedef struct packed {
        aluop_t   aluop;
        alusel_t  alusel;
        word_t    reg1;
        word_t    reg2; // immediate already merged here
        regaddr_t wd;
        logic     wreg;
        word_t    link_addr;
    } ex_op_t;

    typedef struct packed {
        regaddr_t wd;
        logic     wreg;
        word_t    wdata;
        logic     whilo;
        word_t    hi;
        word_t    lo;
    } ex_res_t;

endpackage

/* logic/pipe_reg.sv */
`timescale 1ns/1ns

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_i,

    input  logic in_valid_i,
    output logic in_ready_o,
    input  T     in_data_i,

    output logic out_valid_o,
    input  logic out_ready_i,
    output T     out_data_o
);

    logic valid_q;
    T     data_q;

    // free now, or emptied on this edge
    assign in_ready_o = !valid_q || out_ready_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (in_valid_i && in_ready_o) begin
            valid_q <= 1'b1;
        end else if (out_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

endmodule

/* logic/ex_ctrl.sv */
`timescale 1ns/1ns

module ex_ctrl (
    input  logic            clk,
    input  logic            rst_i,

    input  logic            op_valid_i,
    input  ex_pkg::aluop_t  op_aluop_i,
    input  logic            cnt_done_i,
    input  logic            res_ready_i,

    output logic            op_pop_o,
    output logic            res_push_o,
    output logic            mult_start_o
);

    import ex_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        MUL_RUN,
        MUL_DONE
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   is_mul;

    assign is_mul = (op_aluop_i == EXE_MULT_OP) || (op_aluop_i == EXE_MULTU_OP);

    always_comb begin
        state_d      = state_q;
        mult_start_o = 1'b0;
        res_push_o   = 1'b0;
        case (state_q)
            IDLE: begin
                if (op_valid_i && is_mul) begin
                    mult_start_o = 1'b1; // load counter and operands
                    state_d      = MUL_RUN;
                end else if (op_valid_i) begin
                    res_push_o = 1'b1;
                end
            end
            MUL_RUN: begin
                if (cnt_done_i) begin
                    res_push_o = 1'b1;
                    state_d    = res_ready_i ? IDLE : MUL_DONE;
                end
            end
            MUL_DONE: begin
                res_push_o = 1'b1; // product held, waiting on result stage
                if (res_ready_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign op_pop_o = res_push_o && res_ready_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

/* logic/mult_counter.sv */
`timescale 1ns/1ns

module mult_counter #(
    parameter int MULT_BITS = 2
) (
    input  logic clk,
    input  logic rst_i,
    input  logic load_i,
    output logic cnt_done_o
);

    localparam int STEPS = 32 / MULT_BITS;
    localparam int CW    = $clog2(STEPS + 1);

    logic [CW-1:0] cnt_q;

    // the load edge already performs the first step
    always_ff @(posedge clk) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= CW'(STEPS - 1);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign cnt_done_o = (cnt_q == '0);

endmodule

/* logic/mult_iter.sv */
`timescale 1ns/1ns

module mult_iter #(
    parameter int MULT_BITS = 2
) (
    input  logic          clk,
    input  logic          rst_i,
    input  logic          start_i,
    input  logic          signed_i,
    input  ex_pkg::word_t a_i,
    input  ex_pkg::word_t b_i,
    output ex_pkg::word_t hi_o,
    output ex_pkg::word_t lo_o
);

    import ex_pkg::*;

    logic        a_neg;
    logic        b_neg;
    word_t       a_mag;
    word_t       b_mag;
    logic        neg_q;
    logic [63:0] acc_q;
    logic [63:0] mcand_q;
    word_t       mplier_q;
    logic [63:0] product;

    function automatic logic [63:0] partial(input logic [63:0] mcand, input word_t mplier);
        logic [63:0] sum;
        sum = '0;
        for (int i = 0; i < MULT_BITS; i++) begin
            if (mplier[i]) begin
                sum = sum + (mcand << i);
            end
        end
        return sum;
    endfunction

    assign a_neg = signed_i && a_i[31];
    assign b_neg = signed_i && b_i[31];
    assign a_mag = a_neg ? (~a_i + 1'b1) : a_i; // most negative stays 2^31
    assign b_mag = b_neg ? (~b_i + 1'b1) : b_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            acc_q <= '0;
            neg_q <= 1'b0;
        end else if (start_i) begin
            acc_q <= partial({32'd0, a_mag}, b_mag);
            neg_q <= a_neg ^ b_neg;
        end else begin
            acc_q <= acc_q + partial(mcand_q, mplier_q); // adds zero once drained
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            mcand_q  <= {32'd0, a_mag} << MULT_BITS;
            mplier_q <= b_mag >> MULT_BITS;
        end else begin
            mcand_q  <= mcand_q << MULT_BITS;
            mplier_q <= mplier_q >> MULT_BITS;
        end
    end

    assign product = neg_q ? (~acc_q + 1'b1) : acc_q;
    assign hi_o    = product[63:32];
    assign lo_o    = product[31:0];

endmodule

/* logic/hilo_reg.sv */
`timescale 1ns/1ns

module hilo_reg (
    input  logic          clk,
    input  logic          rst_i,

    input  logic          wr_i,
    input  ex_pkg::word_t wr_hi_i,
    input  ex_pkg::word_t wr_lo_i,

    input  logic          fwd_i,
    input  ex_pkg::word_t fwd_hi_i,
    input  ex_pkg::word_t fwd_lo_i,

    output ex_pkg::word_t hi_o,
    output ex_pkg::word_t lo_o
);

    import ex_pkg::*;

    word_t hi_q;
    word_t lo_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (wr_i) begin
            hi_q <= wr_hi_i;
            lo_q <= wr_lo_i;
        end
    end

    // pending write in the result stage wins
    assign hi_o = fwd_i ? fwd_hi_i : hi_q;
    assign lo_o = fwd_i ? fwd_lo_i : lo_q;

endmodule

/* logic/ex_alu.sv */
`timescale 1ns/1ns

module ex_alu (
    input  ex_pkg::ex_op_t  op_i,
    input  ex_pkg::word_t   hi_i,
    input  ex_pkg::word_t   lo_i,
    input  ex_pkg::word_t   mul_hi_i,
    input  ex_pkg::word_t   mul_lo_i,
    output ex_pkg::ex_res_t res_o
);

    import ex_pkg::*;

    word_t      logic_res;
    word_t      shift_res;
    word_t      move_res;
    word_t      arith_res;
    word_t      operand_b;
    word_t      wdata;
    word_t      hi_res;
    word_t      lo_res;
    logic       whilo;
    logic [4:0] sa;

    assign sa = op_i.reg1[4:0];

    always_comb begin
        case (op_i.aluop)
            EXE_OR_OP:  logic_res = op_i.reg1 | op_i.reg2;
            EXE_AND_OP: logic_res = op_i.reg1 & op_i.reg2;
            EXE_NOR_OP: logic_res = ~(op_i.reg1 | op_i.reg2);
            EXE_XOR_OP: logic_res = op_i.reg1 ^ op_i.reg2;
            default:    logic_res = '0;
        endcase
    end

    always_comb begin
        case (op_i.aluop)
            EXE_SLL_OP: shift_res = op_i.reg2 << sa;
            EXE_SRL_OP: shift_res = op_i.reg2 >> sa;
            EXE_SRA_OP: begin
                // top sa bits take the sign
                shift_res = (op_i.reg2 >> sa) |
                            (~(32'hffff_ffff >> sa) & {32{op_i.reg2[31]}});
            end
            default:    shift_res = '0;
        endcase
    end

    always_comb begin
        case (op_i.aluop)
            EXE_MFHI_OP: move_res = hi_i;
            EXE_MFLO_OP: move_res = lo_i;
            EXE_MOVZ_OP: move_res = op_i.reg1; // zero test done in decode
            EXE_MOVN_OP: move_res = op_i.reg1;
            default:     move_res = '0;
        endcase
    end

    // subtract as add of two's complement
    assign operand_b = ((op_i.aluop == EXE_SUB_OP) || (op_i.aluop == EXE_SUBU_OP)) ?
                       (~op_i.reg2 + 1'b1) : op_i.reg2;

    always_comb begin
        case (op_i.aluop)
            EXE_ADD_OP, EXE_ADDU_OP, EXE_SUB_OP, EXE_SUBU_OP: begin
                arith_res = op_i.reg1 + operand_b; // no overflow trap
            end
            default: begin
                arith_res = '0;
            end
        endcase
    end

    always_comb begin
        case (op_i.alusel)
            EXE_RES_LOGIC:       wdata = logic_res;
            EXE_RES_SHIFT:       wdata = shift_res;
            EXE_RES_MOVE:        wdata = move_res;
            EXE_RES_ARITHMETIC:  wdata = arith_res;
            EXE_RES_JUMP_BRANCH: wdata = op_i.link_addr;
            default:             wdata = '0;
        endcase
    end

    always_comb begin
        whilo  = 1'b0;
        hi_res = '0;
        lo_res = '0;
        if (op_i.alusel == EXE_RES_MUL) begin
            whilo  = 1'b1;
            hi_res = mul_hi_i;
            lo_res = mul_lo_i;
        end else if (op_i.aluop == EXE_MTHI_OP) begin
            whilo  = 1'b1;
            hi_res = op_i.reg1;
            lo_res = lo_i; // other half unchanged
        end else if (op_i.aluop == EXE_MTLO_OP) begin
            whilo  = 1'b1;
            hi_res = hi_i;
            lo_res = op_i.reg1;
        end
    end

    always_comb begin
        res_o.wd    = op_i.wd;
        res_o.wreg  = op_i.wreg;
        res_o.wdata = wdata;
        res_o.whilo = whilo;
        res_o.hi    = hi_res;
        res_o.lo    = lo_res;
    end

endmodule

/* logic/ex_unit.sv */
`timescale 1ns/1ns

module ex_unit #(
    parameter int MULT_BITS = ex_pkg::MULT_BITS_DEFAULT
) (
    input  logic            clk,
    input  logic            rst_i,

    input  logic            op_valid_i,
    output logic            op_ready_o,
    input  ex_pkg::ex_op_t  op_i,

    output logic            res_valid_o,
    input  logic            res_ready_i,
    output ex_pkg::ex_res_t res_o
);

    import ex_pkg::*;

    ex_op_t  op_q;
    ex_res_t alu_res;
    logic    op_valid;
    logic    op_pop;
    logic    res_push;
    logic    res_ready;
    logic    mult_start;
    logic    cnt_done;
    word_t   mul_hi;
    word_t   mul_lo;
    word_t   hi_fwd;
    word_t   lo_fwd;
    logic    hilo_pend;
    logic    hilo_wr;

    assign hilo_pend = res_valid_o && res_o.whilo;
    assign hilo_wr   = hilo_pend && res_ready_i; // commits as it leaves

    pipe_reg #(.T(ex_op_t)) u_op_stage (
        .clk         (clk),
        .rst_i       (rst_i),
        .in_valid_i  (op_valid_i),
        .in_ready_o  (op_ready_o),
        .in_data_i   (op_i),
        .out_valid_o (op_valid),
        .out_ready_i (op_pop),
        .out_data_o  (op_q)
    );

    ex_ctrl u_ctrl (
        .clk          (clk),
        .rst_i        (rst_i),
        .op_valid_i   (op_valid),
        .op_aluop_i   (op_q.aluop),
        .cnt_done_i   (cnt_done),
        .res_ready_i  (res_ready),
        .op_pop_o     (op_pop),
        .res_push_o   (res_push),
        .mult_start_o (mult_start)
    );

    mult_counter #(.MULT_BITS(MULT_BITS)) u_cnt (
        .clk        (clk),
        .rst_i      (rst_i),
        .load_i     (mult_start),
        .cnt_done_o (cnt_done)
    );

    mult_iter #(.MULT_BITS(MULT_BITS)) u_mul (
        .clk      (clk),
        .rst_i    (rst_i),
        .start_i  (mult_start),
        .signed_i (op_q.aluop == EXE_MULT_OP),
        .a_i      (op_q.reg1),
        .b_i      (op_q.reg2),
        .hi_o     (mul_hi),
        .lo_o     (mul_lo)
    );

    ex_alu u_alu (
        .op_i     (op_q),
        .hi_i     (hi_fwd),
        .lo_i     (lo_fwd),
        .mul_hi_i (mul_hi),
        .mul_lo_i (mul_lo),
        .res_o    (alu_res)
    );

    hilo_reg u_hilo (
        .clk      (clk),
        .rst_i    (rst_i),
        .wr_i     (hilo_wr),
        .wr_hi_i  (res_o.hi),
        .wr_lo_i  (res_o.lo),
        .fwd_i    (hilo_pend),
        .fwd_hi_i (res_o.hi),
        .fwd_lo_i (res_o.lo),
        .hi_o     (hi_fwd),
        .lo_o     (lo_fwd)
    );

    pipe_reg #(.T(ex_res_t)) u_res_stage (
        .clk         (clk),
        .rst_i       (rst_i),
        .in_valid_i  (res_push),
        .in_ready_o  (res_ready),
        .in_data_i   (alu_res),
        .out_valid_o (res_valid_o),
        .out_ready_i (res_ready_i),
        .out_data_o  (res_o)
    );

endmodule

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD = 8
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

/* sim/ex_unit_chk.sv */
`timescale 1ns/1ns

module ex_unit_chk (
    input logic            clk,
    input logic            rst_i,
    input logic            op_valid_i,
    input logic            op_ready_o,
    input ex_pkg::ex_op_t  op_i,
    input logic            res_valid_o,
    input logic            res_ready_i,
    input ex_pkg::ex_res_t res_o
);

    res_idle_after_reset: assert property (@(posedge clk) rst_i |=> !res_valid_o)
        else $error("result valid in the cycle after reset");

    res_held: assert property (@(posedge clk) disable iff (rst_i)
        res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o))
        else $error("result dropped or changed before it was taken");

    // source must keep offering while the unit stalls
    op_held: assert property (@(posedge clk) disable iff (rst_i)
        op_valid_i && !op_ready_o |=> op_valid_i && $stable(op_i))
        else $error("offered operation dropped while op_ready_o was low");

endmodule

bind ex_unit ex_unit_chk u_chk (
    .clk         (clk),
    .rst_i       (rst_i),
    .op_valid_i  (op_valid_i),
    .op_ready_o  (op_ready_o),
    .op_i        (op_i),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_o       (res_o)
);

/* sim/tb_ex_unit.sv */
`timescale 1ns/1ns

module tb_ex_unit;

    import ex_pkg::*;

    localparam int WAIT_LIMIT = 1000;

    logic    clk;
    logic    rst_i;
    logic    op_valid_i;
    logic    op_ready_o;
    ex_op_t  op_i;
    logic    res_valid_o;
    logic    res_ready_i;
    ex_res_t res_o;

    int      seed = 11;
    int      ready_seed = 11;
    int      ready_mode = 0; // 0 high, 1 random, 2 low
    int      drive_errors = 0;
    int      cmp_errors = 0;
    int      checks = 0;
    int      tests_run = 0;
    int      tests_failed = 0;
    int      op_count = 0;
    bit      aborted = 1'b0;
    word_t   model_hi = '0;
    word_t   model_lo = '0;
    ex_res_t exp_res;
    ex_res_t exp_q[$];

    tb_clk_gen #(.PERIOD(8)) u_clk (.clk_o(clk));

    ex_unit #(.MULT_BITS(MULT_BITS_DEFAULT)) ex_unit_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .op_valid_i  (op_valid_i),
        .op_ready_o  (op_ready_o),
        .op_i        (op_i),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_o       (res_o)
    );

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    function automatic int total_errors();
        return drive_errors + cmp_errors;
    endfunction

    // what decode would hand over
    function automatic ex_op_t make_op(input aluop_t aluop, input word_t a, input word_t b);
        ex_op_t op;
        op       = '0;
        op.aluop = aluop;
        op.reg1  = a;
        op.reg2  = b;
        op.wd    = regaddr_t'(op_count % 31 + 1);
        op.wreg  = 1'b1;
        op_count++;
        case (aluop)
            EXE_OR_OP, EXE_AND_OP, EXE_NOR_OP, EXE_XOR_OP: op.alusel = EXE_RES_LOGIC;
            EXE_SLL_OP, EXE_SRL_OP, EXE_SRA_OP: op.alusel = EXE_RES_SHIFT;
            EXE_ADD_OP, EXE_ADDU_OP, EXE_SUB_OP, EXE_SUBU_OP: op.alusel = EXE_RES_ARITHMETIC;
            EXE_MOVZ_OP, EXE_MOVN_OP, EXE_MFHI_OP, EXE_MFLO_OP: op.alusel = EXE_RES_MOVE;
            EXE_MULT_OP, EXE_MULTU_OP: begin
                op.alusel = EXE_RES_MUL;
                op.wreg   = 1'b0;
            end
            default: begin
                op.alusel = EXE_RES_NOP;
                op.wreg   = 1'b0;
            end
        endcase
        return op;
    endfunction

    function automatic ex_op_t make_link(input word_t link);
        ex_op_t op;
        op           = make_op(EXE_NOP_OP, '0, '0);
        op.alusel    = EXE_RES_JUMP_BRANCH;
        op.wreg      = 1'b1;
        op.link_addr = link;
        return op;
    endfunction

    // expected result, HI/LO model updated in issue order
    function automatic ex_res_t ref_exec(input ex_op_t op);
        ex_res_t     r;
        logic [63:0] prod;
        r      = '0;
        r.wd   = op.wd;
        r.wreg = op.wreg;
        case (op.aluop)
            EXE_OR_OP:   r.wdata = op.reg1 | op.reg2;
            EXE_AND_OP:  r.wdata = op.reg1 & op.reg2;
            EXE_NOR_OP:  r.wdata = ~(op.reg1 | op.reg2);
            EXE_XOR_OP:  r.wdata = op.reg1 ^ op.reg2;
            EXE_SLL_OP:  r.wdata = op.reg2 << op.reg1[4:0];
            EXE_SRL_OP:  r.wdata = op.reg2 >> op.reg1[4:0];
            EXE_SRA_OP:  r.wdata = $signed(op.reg2) >>> op.reg1[4:0];
            EXE_ADD_OP, EXE_ADDU_OP: r.wdata = op.reg1 + op.reg2;
            EXE_SUB_OP, EXE_SUBU_OP: r.wdata = op.reg1 - op.reg2;
            EXE_MOVZ_OP, EXE_MOVN_OP: r.wdata = op.reg1;
            EXE_MFHI_OP: r.wdata = model_hi;
            EXE_MFLO_OP: r.wdata = model_lo;
            EXE_MTHI_OP: begin
                model_hi = op.reg1;
                r.whilo  = 1'b1;
            end
            EXE_MTLO_OP: begin
                model_lo = op.reg1;
                r.whilo  = 1'b1;
            end
            EXE_MULT_OP, EXE_MULTU_OP: begin
                if (op.aluop == EXE_MULT_OP) begin
                    prod = {{32{op.reg1[31]}}, op.reg1} * {{32{op.reg2[31]}}, op.reg2};
                end else begin
                    prod = {32'd0, op.reg1} * {32'd0, op.reg2};
                end
                model_hi = prod[63:32];
                model_lo = prod[31:0];
                r.whilo  = 1'b1;
            end
            default: r.wdata = '0;
        endcase
        if (op.alusel == EXE_RES_JUMP_BRANCH) begin
            r.wdata = op.link_addr;
        end
        r.hi = model_hi;
        r.lo = model_lo;
        return r;
    endfunction

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    endtask

    // called one ns after a rising edge, returns at the same phase
    task automatic send_op(input ex_op_t op);
        int waited;
        if (aborted) begin
            return;
        end
        exp_q.push_back(ref_exec(op));
        op_i       = op;
        op_valid_i = 1'b1;
        waited     = 0;
        @(negedge clk);
        while (!op_ready_o && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!op_ready_o) begin
            $display("error at %0t ns: operation not accepted within %0d cycles", $time, waited);
            drive_errors++;
            aborted = 1'b1;
        end
        @(posedge clk);
        #1;
        if (!aborted) begin
            op_valid_i = 1'b0; // an unaccepted operation stays offered
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT && !aborted) begin
            @(negedge clk);
            waited++;
        end
        if (!aborted && exp_q.size() != 0) begin
            $display("error at %0t ns: %0d results never arrived", $time, exp_q.size());
            drive_errors++;
            aborted = 1'b1;
            exp_q.delete();
        end
        @(posedge clk);
        #1;
    endtask

    task automatic end_test(input int num, input string name, input int start_err);
        tests_run++;
        if (total_errors() != start_err) begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", num, name, total_errors() - start_err);
        end else begin
            $display("test %0d %s: ok", num, name);
        end
    endtask

    task automatic finish_run();
        $display("tests run %0d, tests failed %0d, results checked %0d, errors %0d",
                 tests_run, tests_failed, checks, total_errors());
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    initial begin
        int mode_s;
        int rnd;
        res_ready_i = 1'b1;
        forever begin
            @(negedge clk);
            mode_s = ready_mode;
            @(posedge clk);
            #1;
            if (mode_s == 1) begin
                rnd         = $random(ready_seed);
                res_ready_i = rnd[0];
            end else begin
                res_ready_i = (mode_s == 0);
            end
        end
    end

    // result handshake seen mid-cycle, taken at the next edge
    always @(negedge clk) begin
        if (!rst_i && res_valid_o && res_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("error at %0t ns: result arrived with nothing outstanding", $time);
                cmp_errors++;
            end else begin
                exp_res = exp_q.pop_front();
                checks++;
                if (res_o.wd !== exp_res.wd) begin
                    report_mismatch("res_o.wd", 32'(res_o.wd), 32'(exp_res.wd));
                    cmp_errors++;
                end
                if (res_o.wreg !== exp_res.wreg) begin
                    report_mismatch("res_o.wreg", 32'(res_o.wreg), 32'(exp_res.wreg));
                    cmp_errors++;
                end
                if (res_o.whilo !== exp_res.whilo) begin
                    report_mismatch("res_o.whilo", 32'(res_o.whilo), 32'(exp_res.whilo));
                    cmp_errors++;
                end
                if (exp_res.wreg && res_o.wdata !== exp_res.wdata) begin
                    report_mismatch("res_o.wdata", res_o.wdata, exp_res.wdata);
                    cmp_errors++;
                end
                if (exp_res.whilo && res_o.hi !== exp_res.hi) begin
                    report_mismatch("res_o.hi", res_o.hi, exp_res.hi);
                    cmp_errors++;
                end
                if (exp_res.whilo && res_o.lo !== exp_res.lo) begin
                    report_mismatch("res_o.lo", res_o.lo, exp_res.lo);
                    cmp_errors++;
                end
            end
        end
    end

    initial begin
        int     start_err;
        word_t  vals[5];
        aluop_t mix[20];
        aluop_t pick;
        vals = '{32'h0000_0000, 32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h0000_0001};
        mix  = '{EXE_OR_OP, EXE_AND_OP, EXE_NOR_OP, EXE_XOR_OP, EXE_SLL_OP, EXE_SRL_OP,
                 EXE_SRA_OP, EXE_ADD_OP, EXE_ADDU_OP, EXE_SUB_OP, EXE_SUBU_OP, EXE_MOVZ_OP,
                 EXE_MOVN_OP, EXE_MFHI_OP, EXE_MFLO_OP, EXE_MTHI_OP, EXE_MTLO_OP,
                 EXE_MULT_OP, EXE_MULTU_OP, EXE_NOP_OP};
        rst_i      = 1'b1;
        op_valid_i = 1'b0;
        op_i       = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_i = 1'b0;

        start_err = total_errors();
        for (int i = 0; i < 20; i++) begin
            send_op(make_op(EXE_OR_OP, rand_word(), rand_word()));
            send_op(make_op(EXE_AND_OP, rand_word(), rand_word()));
            send_op(make_op(EXE_NOR_OP, rand_word(), rand_word()));
            send_op(make_op(EXE_XOR_OP, rand_word(), rand_word()));
        end
        wait_drain();
        end_test(1, "logic", start_err);

        start_err = total_errors();
        for (int i = 0; i < 20; i++) begin
            send_op(make_op(EXE_SLL_OP, rand_word() & 32'h1f, rand_word()));
            send_op(make_op(EXE_SRL_OP, rand_word() & 32'h1f, rand_word()));
            send_op(make_op(EXE_SRA_OP, rand_word() & 32'h1f, rand_word()));
            send_op(make_op(EXE_SRA_OP, rand_word() & 32'h1f, rand_word() | 32'h8000_0000));
        end
        wait_drain();
        end_test(2, "shift", start_err);

        start_err = total_errors();
        send_op(make_op(EXE_ADD_OP, 32'h7fff_ffff, 32'h1)); // no trap, wraps
        send_op(make_op(EXE_ADDU_OP, 32'hffff_ffff, 32'h1));
        send_op(make_op(EXE_SUB_OP, 32'h0, 32'h1));
        send_op(make_op(EXE_SUBU_OP, 32'h8000_0000, 32'h1));
        for (int i = 0; i < 20; i++) begin
            send_op(make_op(EXE_ADD_OP, rand_word(), rand_word()));
            send_op(make_op(EXE_ADDU_OP, rand_word(), rand_word()));
            send_op(make_op(EXE_SUB_OP, rand_word(), rand_word()));
            send_op(make_op(EXE_SUBU_OP, rand_word(), rand_word()));
            send_op(make_link(rand_word()));
        end
        wait_drain();
        end_test(3, "arith and link", start_err);

        start_err = total_errors();
        send_op(make_op(EXE_MTHI_OP, rand_word(), '0));
        send_op(make_op(EXE_MFHI_OP, '0, '0));
        send_op(make_op(EXE_MTLO_OP, rand_word(), '0));
        send_op(make_op(EXE_MFLO_OP, '0, '0));
        wait_drain();
        for (int i = 0; i < 2; i++) begin
            ready_mode = 2;
            repeat (2) @(posedge clk);
            #1;
            send_op(make_op(i == 0 ? EXE_MTHI_OP : EXE_MTLO_OP, rand_word(), '0));
            send_op(make_op(i == 0 ? EXE_MFHI_OP : EXE_MFLO_OP, '0, '0));
            @(negedge clk);
            if (op_ready_o !== 1'b0) begin
                report_mismatch("op_ready_o", 32'(op_ready_o), 32'd0);
                drive_errors++;
            end
            repeat (4) @(posedge clk);
            #1;
            ready_mode = 0;
            wait_drain();
        end
        end_test(4, "hilo forwarding", start_err);

        start_err = total_errors();
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                send_op(make_op(EXE_MULT_OP, vals[i], vals[j]));
                send_op(make_op(EXE_MFHI_OP, '0, '0));
                send_op(make_op(EXE_MULTU_OP, vals[i], vals[j]));
                send_op(make_op(EXE_MFLO_OP, '0, '0));
            end
        end
        for (int i = 0; i < 10; i++) begin
            send_op(make_op(EXE_MULT_OP, rand_word(), rand_word()));
            send_op(make_op(EXE_MFHI_OP, '0, '0));
            send_op(make_op(EXE_MFLO_OP, '0, '0));
            send_op(make_op(EXE_MULTU_OP, rand_word(), rand_word()));
            send_op(make_op(EXE_MFLO_OP, '0, '0));
            send_op(make_op(EXE_MFHI_OP, '0, '0));
        end
        wait_drain();
        end_test(5, "multiply", start_err);

        start_err  = total_errors();
        ready_mode = 1;
        for (int i = 0; i < 300; i++) begin
            pick = mix[int'(rand_word() % 32'd20)];
            if (pick == EXE_NOP_OP) begin
                send_op(make_link(rand_word()));
            end else begin
                send_op(make_op(pick, rand_word(), rand_word()));
            end
        end
        wait_drain();
        ready_mode = 0;
        end_test(6, "mixed stream with back-pressure", start_err);

        finish_run();
    end

endmodule

/* filelist.f */
logic/ex_pkg.sv
logic/pipe_reg.sv
logic/ex_ctrl.sv
logic/mult_counter.sv
logic/mult_iter.sv
logic/hilo_reg.sv
logic/ex_alu.sv
logic/ex_unit.sv
sim/tb_clk_gen.sv
sim/ex_unit_chk.sv
sim/tb_ex_unit.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_ex_unit
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := ALL TESTS PASSED
FAIL_MSG  := SOME TESTS FAILED
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
